// ==== rtl/tcdm_pkg.sv ====
// ********************
// shared tcdm types and constants, imported by all rtl blocks
// ********************
`default_nettype none

package tcdm_pkg;

  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;
  localparam int unsigned BE_W   = DATA_W / 8;

  typedef logic [ADDR_W-1:0] addr_t;  // byte address
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [BE_W-1:0]   be_t;    // one enable per byte
  typedef logic              opc_t;   // 0 ok, 1 error

  // returned on a miss of every region
  localparam data_t ERR_DATA = 32'hbadacce5;

  // response source of the filter, one cycle after acceptance
  typedef enum logic [1:0] {
    IDLE,
    ON_TCDM,
    ON_PER,
    ERROR
  } route_state_e;

endpackage

`default_nettype wire

// ==== rtl/tcdm_intf.sv ====
// ********************
// req/gnt tcdm link, one r_valid pulse per accepted request
// ********************
`default_nettype none

interface tcdm_intf
  import tcdm_pkg::*;
();

  // request side
  logic  req;
  logic  gnt;
  addr_t add;
  logic  wen;   // 1 read, 0 write
  be_t   be;
  data_t data;

  // response side
  logic  r_valid;
  data_t r_data;
  opc_t  r_opc;

  modport initiator (
    output req, add, wen, be, data,
    input  gnt, r_valid, r_data, r_opc
  );

  modport target (
    input  req, add, wen, be, data,
    output gnt, r_valid, r_data, r_opc
  );

endinterface

`default_nettype wire

// ==== rtl/memmap_filter.sv ====
// ********************
// address decode to the banks, the peripherals or a local error reply
// ********************
`default_nettype none

module memmap_filter
  import tcdm_pkg::*;
#(
  parameter int unsigned NB_REGION = 2
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   clear_i,
  input  addr_t [NB_REGION-1:0]  region_start_addr,
  input  addr_t [NB_REGION-1:0]  region_end_addr,
  tcdm_intf.target               slave,
  tcdm_intf.initiator            tcdm_master,
  tcdm_intf.initiator            per_master
);

  route_state_e state_q, state_d;

  logic [NB_REGION-1:0] destination_map;
  logic                 dest_tcdm;
  logic                 dest_per;

  // half-open range per region
  always_comb begin
    destination_map = '0;
    for (int unsigned i = 0; i < NB_REGION; i++) begin
      if ((slave.add >= region_start_addr[i]) && (slave.add < region_end_addr[i])) begin
        destination_map[i] = 1'b1;
      end
    end
  end

  assign dest_tcdm = destination_map[0];                    // region 0 wins on overlap
  assign dest_per  = ~dest_tcdm & (|destination_map[NB_REGION-1:1]);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else if (clear_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // hold in ON_PER until the peripheral answers
  always_comb begin
    state_d = state_q;
    if ((state_q != ON_PER) || per_master.r_valid) begin
      if (!slave.req) begin
        state_d = IDLE;
      end else if (dest_tcdm) begin
        state_d = tcdm_master.gnt ? ON_TCDM : IDLE;
      end else if (dest_per) begin
        state_d = per_master.gnt ? ON_PER : IDLE;
      end else begin
        state_d = ERROR;
      end
    end
  end

  // request routing, one target at most
  assign tcdm_master.req  = slave.req & dest_tcdm;
  assign tcdm_master.add  = slave.add;
  assign tcdm_master.wen  = slave.wen;
  assign tcdm_master.be   = slave.be;
  assign tcdm_master.data = slave.data;

  assign per_master.req  = slave.req & dest_per;
  assign per_master.add  = slave.add;
  assign per_master.wen  = slave.wen;
  assign per_master.be   = slave.be;
  assign per_master.data = slave.data;

  assign slave.gnt = tcdm_master.gnt | per_master.gnt | (slave.req & ~(|destination_map));

  always_comb begin
    slave.r_valid = 1'b0;
    slave.r_data  = '0;
    slave.r_opc   = 1'b0;
    unique case (state_q)
      ON_TCDM: begin
        slave.r_valid = tcdm_master.r_valid;
        slave.r_data  = tcdm_master.r_data;
        slave.r_opc   = tcdm_master.r_opc;
      end
      ON_PER: begin
        slave.r_valid = per_master.r_valid;
        slave.r_data  = per_master.r_data;
        slave.r_opc   = per_master.r_opc;
      end
      ERROR: begin
        slave.r_valid = 1'b1;     // unmapped, answered locally
        slave.r_data  = ERR_DATA;
        slave.r_opc   = 1'b1;
      end
      default: ;                  // IDLE, nothing in flight
    endcase
  end

endmodule

`default_nettype wire

// ==== rtl/bank_demux.sv ====
// ********************
// word-interleaved bank select, responses come back via the merger
// ********************
`default_nettype none

module bank_demux #(
  parameter int unsigned NB_BANKS = 4
) (
  tcdm_intf.target    up,
  tcdm_intf.initiator banks [NB_BANKS],
  tcdm_intf.target    merged
);

  localparam int unsigned BANK_BITS = $clog2(NB_BANKS);

  logic [BANK_BITS-1:0] bank_sel;
  logic [NB_BANKS-1:0]  bank_gnt;

  assign bank_sel = up.add[2 +: BANK_BITS];  // bits right above the byte offset

  for (genvar i = 0; i < NB_BANKS; i++) begin : gen_fwd
    assign banks[i].req  = up.req & (bank_sel == i);
    assign banks[i].add  = up.add;
    assign banks[i].wen  = up.wen;
    assign banks[i].be   = up.be;
    assign banks[i].data = up.data;
    assign bank_gnt[i]   = banks[i].gnt;
  end

  assign up.gnt = bank_gnt[bank_sel];

  // response from the merger
  assign up.r_valid = merged.r_valid;
  assign up.r_data  = merged.r_data;
  assign up.r_opc   = merged.r_opc;

endmodule

`default_nettype wire

// ==== rtl/tcdm_bank.sv ====
// ********************
// single sram bank, byte-enabled writes, response one cycle later
// ********************
`default_nettype none

module tcdm_bank
  import tcdm_pkg::*;
#(
  parameter int unsigned NB_BANKS   = 4,
  parameter int unsigned BANK_WORDS = 64
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  tcdm_intf.target port
);

  localparam int unsigned BANK_BITS = $clog2(NB_BANKS);
  localparam int unsigned ROW_BITS  = $clog2(BANK_WORDS);

  data_t                mem_q [BANK_WORDS];
  logic [ROW_BITS-1:0]  row;
  logic                 r_valid_q;
  data_t                r_data_q;

  assign row = port.add[2 + BANK_BITS +: ROW_BITS];

  always_ff @(posedge clk_i) begin
    if (port.req && !port.wen) begin
      for (int unsigned b = 0; b < BE_W; b++) begin
        if (port.be[b]) mem_q[row][8*b +: 8] <= port.data[8*b +: 8];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      r_valid_q <= 1'b0;
    end else begin
      r_valid_q <= port.req;   // always granted
    end
  end

  always_ff @(posedge clk_i) begin
    if (port.req) r_data_q <= port.wen ? mem_q[row] : '0;  // writes answer 0
  end

  assign port.gnt     = port.req;
  assign port.r_valid = r_valid_q;
  assign port.r_data  = r_data_q;
  assign port.r_opc   = 1'b0;

endmodule

`default_nettype wire

// ==== rtl/resp_merge.sv ====
// ********************
// one-hot and-or of the bank responses onto a single channel
// ********************
`default_nettype none

module resp_merge
  import tcdm_pkg::*;
#(
  parameter int unsigned NB_BANKS = 4
) (
  tcdm_intf.target banks [NB_BANKS],
  tcdm_intf.target merged
);

  logic [NB_BANKS-1:0] valid_vec;
  data_t               data_vec [NB_BANKS];
  opc_t                opc_vec  [NB_BANKS];

  for (genvar i = 0; i < NB_BANKS; i++) begin : gen_collect
    assign valid_vec[i] = banks[i].r_valid;
    assign data_vec[i]  = banks[i].r_data;
    assign opc_vec[i]   = banks[i].r_opc;
  end

  // at most one bank valid per cycle
  always_comb begin
    merged.r_data = '0;
    merged.r_opc  = 1'b0;
    for (int unsigned i = 0; i < NB_BANKS; i++) begin
      if (valid_vec[i]) begin
        merged.r_data = merged.r_data | data_vec[i];
        merged.r_opc  = merged.r_opc | opc_vec[i];
      end
    end
  end

  assign merged.r_valid = |valid_vec;

endmodule

`default_nettype wire

// ==== rtl/periph_regs.sv ====
// ********************
// peripheral register file behind region 1
// ********************
`default_nettype none

module periph_regs
  import tcdm_pkg::*;
#(
  parameter int unsigned NB_REGS = 8
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  tcdm_intf.target port
);

  localparam int unsigned IDX_BITS = $clog2(NB_REGS);

  data_t               regs_q [NB_REGS];
  logic [IDX_BITS-1:0] idx;
  logic                r_valid_q;
  data_t               r_data_q;

  assign idx = port.add[2 +: IDX_BITS];   // wraps modulo NB_REGS

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int unsigned r = 0; r < NB_REGS; r++) begin
        regs_q[r] <= '0;
      end
    end else if (port.req && !port.wen) begin
      for (int unsigned b = 0; b < BE_W; b++) begin
        if (port.be[b]) regs_q[idx][8*b +: 8] <= port.data[8*b +: 8];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      r_valid_q <= 1'b0;
    end else begin
      r_valid_q <= port.req;
    end
  end

  always_ff @(posedge clk_i) begin
    if (port.req) r_data_q <= port.wen ? regs_q[idx] : '0;
  end

  assign port.gnt     = port.req;  // no wait states
  assign port.r_valid = r_valid_q;
  assign port.r_data  = r_data_q;
  assign port.r_opc   = 1'b0;

endmodule

`default_nettype wire

// ==== rtl/tcdm_subsystem_top.sv ====
// ********************
// tcdm subsystem, one initiator port over banks and peripheral regs
// ********************
`default_nettype none

module tcdm_subsystem_top
  import tcdm_pkg::*;
#(
  parameter int unsigned NB_BANKS   = 4,
  parameter int unsigned BANK_WORDS = 64,
  parameter int unsigned NB_REGS    = 8
) (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  clear_i,
  input  addr_t region0_start,
  input  addr_t region0_end,
  input  addr_t region1_start,
  input  addr_t region1_end,
  input  logic  req,
  input  addr_t add,
  input  logic  wen,
  input  be_t   be,
  input  data_t data,
  output logic  gnt,
  output logic  r_valid,
  output data_t r_data,
  output opc_t  r_opc
);

  localparam int unsigned NB_REGION = 2;

  tcdm_intf in_if ();
  tcdm_intf tcdm_if ();
  tcdm_intf per_if ();
  tcdm_intf merged_if ();
  tcdm_intf bank_if [NB_BANKS] ();

  // plain ports onto the filter link
  assign in_if.req  = req;
  assign in_if.add  = add;
  assign in_if.wen  = wen;
  assign in_if.be   = be;
  assign in_if.data = data;
  assign gnt        = in_if.gnt;
  assign r_valid    = in_if.r_valid;
  assign r_data     = in_if.r_data;
  assign r_opc      = in_if.r_opc;

  memmap_filter #(
    .NB_REGION (NB_REGION)
  ) i_filter (
    .clk_i,
    .rst_ni,
    .clear_i,
    .region_start_addr ({region1_start, region0_start}),
    .region_end_addr   ({region1_end, region0_end}),
    .slave             (in_if),
    .tcdm_master       (tcdm_if),
    .per_master        (per_if)
  );

  bank_demux #(.NB_BANKS(NB_BANKS)) i_demux (
    .up     (tcdm_if),
    .banks  (bank_if),
    .merged (merged_if)
  );

  for (genvar i = 0; i < NB_BANKS; i++) begin : gen_bank
    tcdm_bank #(
      .NB_BANKS   (NB_BANKS),
      .BANK_WORDS (BANK_WORDS)
    ) i_bank (
      .clk_i,
      .rst_ni,
      .port (bank_if[i])
    );
  end

  resp_merge #(.NB_BANKS(NB_BANKS)) i_merge (
    .banks  (bank_if),
    .merged (merged_if)
  );

  periph_regs #(.NB_REGS(NB_REGS)) i_periph (
    .clk_i,
    .rst_ni,
    .port (per_if)
  );

endmodule

`default_nettype wire

// ==== testbench/tb_tcdm_subsystem.sv ====
// ********************
// testbench for the tcdm subsystem, runs standalone with a self-checking
// reference model of both regions and the unmapped error reply
// ********************
`default_nettype none

module tb_tcdm_subsystem
  import tcdm_pkg::*;
();

  timeunit 1ns;
  timeprecision 10ps;

  localparam int unsigned NB_BANKS      = 4;
  localparam int unsigned BANK_WORDS    = 64;
  localparam int unsigned NB_REGS       = 8;
  localparam int unsigned R0_WORDS      = NB_BANKS * BANK_WORDS;
  localparam addr_t       R0_START      = 32'h1000_0000;
  localparam addr_t       R0_END        = R0_START + R0_WORDS * 4;
  localparam addr_t       R1_START      = 32'h2000_0000;
  localparam addr_t       R1_END        = R1_START + NB_REGS * 4;
  localparam int unsigned GNT_TIMEOUT   = 16;
  localparam int unsigned DRAIN_TIMEOUT = 64;

  logic  clk_i;
  logic  rst_ni;
  logic  clear_i;
  addr_t region0_start;
  addr_t region0_end;
  addr_t region1_start;
  addr_t region1_end;
  logic  req;
  addr_t add;
  logic  wen;
  be_t   be;
  data_t data;
  logic  gnt;
  logic  r_valid;
  data_t r_data;
  opc_t  r_opc;

  data_t       mem0_model [int unsigned];  // region 0, by word index
  data_t       mem1_model [int unsigned];  // region 1, by register index
  data_t       exp_data_q [$];
  opc_t        exp_opc_q [$];
  int unsigned exp_cycle_q [$];           // acceptance cycle of each entry
  int unsigned cycle;
  int unsigned checks;
  int unsigned errors;

  tcdm_subsystem_top #(
    .NB_BANKS   (NB_BANKS),
    .BANK_WORDS (BANK_WORDS),
    .NB_REGS    (NB_REGS)
  ) i_dut (
    .clk_i,
    .rst_ni,
    .clear_i,
    .region0_start,
    .region0_end,
    .region1_start,
    .region1_end,
    .req,
    .add,
    .wen,
    .be,
    .data,
    .gnt,
    .r_valid,
    .r_data,
    .r_opc
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  function automatic data_t merge_bytes(input data_t old, input data_t wdata, input be_t be_v);
    data_t res;
    res = old;
    for (int b = 0; b < BE_W; b++) begin
      if (be_v[b]) begin
        res[8*b +: 8] = wdata[8*b +: 8];
      end
    end
    return res;
  endfunction

  // expected response of one accepted request, updates the model on writes
  function automatic data_t predict_resp(input addr_t a, input logic rd, input be_t be_v,
                                         input data_t wdata, output opc_t opc);
    int unsigned idx;
    data_t       word;
    opc = 1'b0;
    if ((a >= R0_START) && (a < R0_END)) begin
      idx  = (a - R0_START) >> 2;
      word = mem0_model.exists(idx) ? mem0_model[idx] : '0;
      if (rd) return word;
      mem0_model[idx] = merge_bytes(word, wdata, be_v);
      return '0;
    end
    if ((a >= R1_START) && (a < R1_END)) begin
      idx  = ((a - R1_START) >> 2) % NB_REGS;
      word = mem1_model.exists(idx) ? mem1_model[idx] : '0;  // regs reset to 0
      if (rd) return word;
      mem1_model[idx] = merge_bytes(word, wdata, be_v);
      return '0;
    end
    opc = 1'b1;
    return ERR_DATA;
  endfunction

  // compare first, then record this edge's accepted request
  always @(posedge clk_i) begin
    data_t       exp_d;
    opc_t        exp_o;
    int unsigned exp_c;
    data_t       pred_d;
    opc_t        pred_o;
    cycle++;
    if (r_valid === 1'b1) begin
      if (exp_data_q.size() == 0) begin
        $display("response at cycle %0d without any outstanding request", cycle);
        errors++;
      end else begin
        exp_d = exp_data_q.pop_front();
        exp_o = exp_opc_q.pop_front();
        exp_c = exp_cycle_q.pop_front();
        checks++;
        assert (r_data === exp_d) else begin
          $display("FAIL r_data: got %h, expected %h", r_data, exp_d);
          errors++;
        end
        assert (r_opc === exp_o) else begin
          $display("FAIL r_opc: got %h, expected %h", r_opc, exp_o);
          errors++;
        end
        assert (cycle == exp_c + 1) else begin
          $display("response for the request of cycle %0d came at cycle %0d", exp_c, cycle);
          errors++;
        end
      end
    end
    if ((req === 1'b1) && (gnt === 1'b1)) begin
      pred_d = predict_resp(add, wen, be, data, pred_o);
      exp_data_q.push_back(pred_d);
      exp_opc_q.push_back(pred_o);
      exp_cycle_q.push_back(cycle);
    end
  end

  // drive one request, return at the edge that accepts it
  task automatic issue(input addr_t a, input logic rd, input be_t be_v, input data_t wdata);
    int unsigned n;
    req  <= 1'b1;
    add  <= a;
    wen  <= rd;
    be   <= be_v;
    data <= wdata;
    @(posedge clk_i);
    n = 1;
    while ((gnt !== 1'b1) && (n < GNT_TIMEOUT)) begin
      @(posedge clk_i);
      n++;
    end
    if (gnt !== 1'b1) begin
      $display("no grant for address %h within %0d cycles", a, GNT_TIMEOUT);
      errors++;
    end else begin
      assert (n == 1) else begin
        $display("grant for address %h came after %0d cycles, not in the request cycle", a, n);
        errors++;
      end
    end
  endtask

  task automatic idle_cycles(input int unsigned n);
    req <= 1'b0;
    repeat (n) @(posedge clk_i);
  endtask

  task automatic wait_drain();
    int unsigned n;
    n = 0;
    while ((exp_data_q.size() != 0) && (n < DRAIN_TIMEOUT)) begin
      @(posedge clk_i);
      n++;
    end
    if (exp_data_q.size() != 0) begin
      $display("%0d responses still missing after %0d cycles", exp_data_q.size(), n);
      errors++;
    end
  endtask

  initial begin
    addr_t       a;
    addr_t       unmapped [5];
    logic        rd;
    be_t         bv;
    data_t       wd;
    int unsigned r;
    void'($urandom(32'hb0ad5f95));
    rst_ni        <= 1'b0;
    clear_i       <= 1'b0;
    region0_start <= R0_START;
    region0_end   <= R0_END;
    region1_start <= R1_START;
    region1_end   <= R1_END;
    req           <= 1'b0;
    add           <= '0;
    wen           <= 1'b1;
    be            <= '0;
    data          <= '0;
    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;

    // quiet bus after reset
    repeat (4) begin
      @(posedge clk_i);
      assert (r_valid === 1'b0) else begin
        $display("FAIL r_valid: got %h, expected %h", r_valid, 1'b0);
        errors++;
      end
    end

    // fill region 0, read back with an odd stride so bank order differs
    for (int unsigned i = 0; i < R0_WORDS; i++) begin
      issue(R0_START + i * 4, 1'b0, 4'hf, $urandom);
    end
    for (int unsigned i = 0; i < R0_WORDS; i++) begin
      issue(R0_START + ((i * 37) % R0_WORDS) * 4, 1'b1, 4'hf, '0);
    end
    idle_cycles(2);
    wait_drain();

    // peripheral regs, top two never written
    repeat (2) begin
      for (int unsigned i = 0; i < NB_REGS - 2; i++) begin
        issue(R1_START + i * 4, 1'b0, be_t'($urandom), $urandom);
      end
    end
    for (int unsigned i = 0; i < NB_REGS; i++) begin
      issue(R1_START + i * 4, 1'b1, 4'hf, '0);
    end
    idle_cycles(2);
    wait_drain();

    // unmapped, each request on its own
    unmapped = '{32'h0000_0000, R0_END, R1_END, 32'h0fff_fffc, 32'hffff_fffc};
    foreach (unmapped[i]) begin
      issue(unmapped[i], 1'b1, 4'hf, '0);
      idle_cycles(1);
      issue(unmapped[i], 1'b0, 4'h3, $urandom);
      idle_cycles(1);
    end
    wait_drain();

    // mixed back-to-back bursts, clear pulse in between
    repeat (3) begin
      repeat (40) begin
        r  = $urandom % 3;
        rd = $urandom % 2;
        bv = be_t'($urandom);
        wd = $urandom;
        if (r == 0) begin
          a = R0_START + ($urandom % R0_WORDS) * 4;
        end else if (r == 1) begin
          a = R1_START + ($urandom % NB_REGS) * 4;
        end else begin
          a = $urandom;
          a[31] = 1'b1;                          // far above both regions
        end
        issue(a, rd, bv, wd);
      end
      idle_cycles(2);
      wait_drain();
      clear_i <= 1'b1;
      @(posedge clk_i);
      clear_i <= 1'b0;
    end
    idle_cycles(2);
    wait_drain();

    $display("%0d responses checked, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
rtl/tcdm_pkg.sv
rtl/tcdm_intf.sv
rtl/memmap_filter.sv
rtl/bank_demux.sv
rtl/tcdm_bank.sv
rtl/resp_merge.sv
rtl/periph_regs.sv
rtl/tcdm_subsystem_top.sv
testbench/tb_tcdm_subsystem.sv

// ==== Bender.yml ====
package:
  name: tcdm_subsystem

sources:
  - files:
      - rtl/tcdm_pkg.sv
      - rtl/tcdm_intf.sv
      - rtl/memmap_filter.sv
      - rtl/bank_demux.sv
      - rtl/tcdm_bank.sv
      - rtl/resp_merge.sv
      - rtl/periph_regs.sv
      - rtl/tcdm_subsystem_top.sv
  - target: test
    files:
      - testbench/tb_tcdm_subsystem.sv
